//--- Makefile
VERILATOR  ?= verilator
TB_TOP     ?= tb_chess_eval_top
RTL_TOP    ?= chess_eval_top
FILELIST   ?= chess_eval_top.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall
RTL_FILES  ?= chess_pkg.sv board_store.sv material_eval.sv chess_regs.sv chess_eval_top.sv
PASS_MSG   := ALL CHECKS PASSED

SOURCES := $(shell cat $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TB_TOP)

$(BUILD_DIR)/V$(TB_TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	-./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_FILES)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- board_store.sv
`timescale 1ns/100ps
`default_nettype none

module board_store (
   input  wire logic                  clk,
   input  wire logic                  rst_n,
   input  wire chess_pkg::sq_write_t  sq_wr,
   input  wire chess_pkg::board_cmd_t board_cmd,
   input  wire chess_pkg::sq_index_t  scan_index,
   input  wire chess_pkg::sq_index_t  sel_index,
   output chess_pkg::piece_t          scan_piece,
   output chess_pkg::piece_t          sel_piece
);

   import chess_pkg::*;

   piece_t board [64];  // One piece code per square

   // Starting piece for a square, white on ranks 0 and 1
   function automatic piece_t opening_piece(sq_index_t sq);
      logic [2:0] rank;
      logic [2:0] file;
      piece_t     back;
      rank = sq[5:3];
      file = sq[2:0];
      case (file)
         3'd0, 3'd7: back = pc_w_rook;
         3'd1, 3'd6: back = pc_w_knit;
         3'd2, 3'd5: back = pc_w_bish;
         3'd3:       back = pc_w_quen;
         default:    back = pc_w_king;
      endcase
      case (rank)
         3'd0:    return back;
         3'd1:    return pc_w_pawn;
         3'd6:    return pc_b_pawn;
         3'd7:    return piece_t'(back | (4'd1 << color_bit)); // Black copy
         default: return pc_empty;
      endcase
   endfunction

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < 64; i++)
            board[i] <= opening_piece(sq_index_t'(i));
      end
      else if (board_cmd.load)
      begin
         for (int i = 0; i < 64; i++)
            board[i] <= opening_piece(sq_index_t'(i));
      end
      else if (board_cmd.clear)
      begin
         for (int i = 0; i < 64; i++)
            board[i] <= pc_empty;
      end
      else if (sq_wr.wr)
         board[sq_wr.index] <= sq_wr.piece; // Commands win over square writes
   end

   // Combinational read ports
   assign scan_piece = board[scan_index];
   assign sel_piece  = board[sel_index];

endmodule

`default_nettype wire

//--- chess_eval_top.f
chess_pkg.sv
board_store.sv
material_eval.sv
chess_regs.sv
chess_eval_top.sv
tb_chess_eval_top.sv

//--- chess_eval_top.sv
`timescale 1ns/100ps
`default_nettype none

module chess_eval_top #(
   parameter int EVAL_WIDTH = 22
) (
   input  wire logic                 clk,
   input  wire logic                 rst_n,
   input  wire logic                 reg_wr,
   input  wire logic                 reg_rd,
   input  wire chess_pkg::reg_addr_t reg_addr,
   input  wire logic [31:0]          reg_wdata,
   output logic [31:0]               reg_rdata
);

   import chess_pkg::*;

   sq_write_t                    sq_wr;      // Regs to store, one square
   board_cmd_t                   board_cmd;  // Clear / opening load
   sq_index_t                    sel_index;
   piece_t                       sel_piece;
   sq_index_t                    scan_index; // Evaluator read port
   piece_t                       scan_piece;
   logic                         eval_start;
   logic                         eval_busy;
   logic                         eval_done;
   logic signed [EVAL_WIDTH-1:0] eval_score;

   chess_regs #(
      .EVAL_WIDTH (EVAL_WIDTH)
   ) u_chess_regs (
      .clk        (clk),
      .rst_n      (rst_n),
      .reg_wr     (reg_wr),
      .reg_rd     (reg_rd),
      .reg_addr   (reg_addr),
      .reg_wdata  (reg_wdata),
      .reg_rdata  (reg_rdata),
      .sq_wr      (sq_wr),
      .board_cmd  (board_cmd),
      .sel_index  (sel_index),
      .sel_piece  (sel_piece),
      .eval_start (eval_start),
      .eval_busy  (eval_busy),
      .eval_done  (eval_done),
      .eval_score (eval_score)
   );

   board_store u_board_store (
      .clk        (clk),
      .rst_n      (rst_n),
      .sq_wr      (sq_wr),
      .board_cmd  (board_cmd),
      .scan_index (scan_index),
      .sel_index  (sel_index),
      .scan_piece (scan_piece),
      .sel_piece  (sel_piece)
   );

   material_eval #(
      .EVAL_WIDTH (EVAL_WIDTH)
   ) u_material_eval (
      .clk        (clk),
      .rst_n      (rst_n),
      .start      (eval_start),
      .scan_index (scan_index),
      .scan_piece (scan_piece),
      .busy       (eval_busy),
      .done       (eval_done),
      .score      (eval_score)
   );

endmodule

`default_nettype wire

//--- chess_pkg.sv
`default_nettype none

package chess_pkg;

   // Piece codes, bit 3 set for black
   typedef enum logic [3:0] {
      pc_empty  = 4'd0,
      pc_w_pawn = 4'd1,
      pc_w_knit = 4'd2,
      pc_w_bish = 4'd3,
      pc_w_rook = 4'd4,
      pc_w_quen = 4'd5,
      pc_w_king = 4'd6,
      pc_b_pawn = 4'd9,
      pc_b_knit = 4'd10,
      pc_b_bish = 4'd11,
      pc_b_rook = 4'd12,
      pc_b_quen = 4'd13,
      pc_b_king = 4'd14
   } piece_t;

   localparam int unsigned color_bit = 3; // Black marker inside piece_t

   typedef enum logic [2:0] {
      reg_cmd    = 3'd0,                  // W: start / clear / load
      reg_square = 3'd1,                  // W: square+piece, R: piece on selected square
      reg_status = 3'd2,                  // R: busy, done
      reg_eval   = 3'd3                   // R: signed score
   } reg_addr_t;

   localparam int unsigned cmd_start_bit   = 0;
   localparam int unsigned cmd_clear_bit   = 1;
   localparam int unsigned cmd_load_bit    = 2;
   localparam int unsigned status_busy_bit = 0;
   localparam int unsigned status_done_bit = 1;

   typedef logic [5:0] sq_index_t;        // Rank * 8 + file

   typedef struct packed {
      logic      wr;                      // Single square write strobe
      sq_index_t index;
      piece_t    piece;
   } sq_write_t;

   typedef struct packed {
      logic clear;                        // Empty all squares
      logic load;                         // Opening position
   } board_cmd_t;

   // Unsigned material value, colour ignored
   function automatic logic [15:0] piece_value(piece_t p);
      case (p)
         pc_w_pawn, pc_b_pawn: return 16'd100;
         pc_w_knit, pc_b_knit: return 16'd320;
         pc_w_bish, pc_b_bish: return 16'd330;
         pc_w_rook, pc_b_rook: return 16'd500;
         pc_w_quen, pc_b_quen: return 16'd900;
         default:              return 16'd0; // Kings and empty squares
      endcase
   endfunction

endpackage

`default_nettype wire

//--- chess_regs.sv
`timescale 1ns/100ps
`default_nettype none

module chess_regs #(
   parameter int EVAL_WIDTH = 22
) (
   input  wire logic                         clk,
   input  wire logic                         rst_n,
   input  wire logic                         reg_wr,
   input  wire logic                         reg_rd,
   input  wire chess_pkg::reg_addr_t         reg_addr,
   input  wire logic [31:0]                  reg_wdata,
   output logic [31:0]                       reg_rdata,
   output chess_pkg::sq_write_t              sq_wr,
   output chess_pkg::board_cmd_t             board_cmd,
   output chess_pkg::sq_index_t              sel_index,
   input  wire chess_pkg::piece_t            sel_piece,
   output logic                              eval_start,
   input  wire logic                         eval_busy,
   input  wire logic                         eval_done,
   input  wire logic signed [EVAL_WIDTH-1:0] eval_score
);

   import chess_pkg::*;

   logic               engine_busy;  // Scan running or start in flight
   logic               wr_ok;        // Write accepted
   logic               cmd_wr;
   logic               square_wr;
   logic               start_q;
   logic               done_q;       // Sticky done
   sq_index_t          sel_q;
   logic [31:0]        rd_mux;
   logic signed [31:0] score_ext;

   // Start pulse is still pending for one cycle before busy rises
   assign engine_busy = eval_busy | start_q;
   assign wr_ok       = reg_wr & ~engine_busy;
   assign cmd_wr      = wr_ok && (reg_addr == reg_cmd);
   assign square_wr   = wr_ok && (reg_addr == reg_square);

   // Board commands go straight to the store, taken at the next edge
   assign sq_wr.wr        = square_wr;
   assign sq_wr.index     = sq_index_t'(reg_wdata[9:4]);
   assign sq_wr.piece     = piece_t'(reg_wdata[3:0]);
   assign board_cmd.clear = cmd_wr & reg_wdata[cmd_clear_bit];
   assign board_cmd.load  = cmd_wr & reg_wdata[cmd_load_bit];

   assign eval_start = start_q;
   assign sel_index  = sel_q;
   assign score_ext  = eval_score;  // Sign extends

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         start_q <= 1'b0;
         done_q  <= 1'b0;
         sel_q   <= '0;
      end
      else
      begin
         start_q <= cmd_wr & reg_wdata[cmd_start_bit]; // One cycle pulse
         if (cmd_wr && reg_wdata[cmd_start_bit])
            done_q <= 1'b0;                           // New run clears done
         else if (eval_done)
            done_q <= 1'b1;
         if (square_wr)
            sel_q <= sq_index_t'(reg_wdata[9:4]);     // Remember last square
      end
   end

   // Read mux, unused addresses give zero
   always_comb
   begin
      rd_mux = '0;
      case (reg_addr)
         reg_square:
            rd_mux[3:0] = sel_piece;
         reg_status:
         begin
            rd_mux[status_busy_bit] = engine_busy;
            rd_mux[status_done_bit] = done_q;
         end
         reg_eval:
            rd_mux = score_ext;
         default:
            rd_mux = '0;               // Cmd is write only
      endcase
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         reg_rdata <= '0;
      else if (reg_rd)
         reg_rdata <= rd_mux;          // Held until next read
   end

endmodule

`default_nettype wire

//--- material_eval.sv
`timescale 1ns/100ps
`default_nettype none

module material_eval #(
   parameter int EVAL_WIDTH = 22
) (
   input  wire logic                    clk,
   input  wire logic                    rst_n,
   input  wire logic                    start,
   output chess_pkg::sq_index_t         scan_index,
   input  wire chess_pkg::piece_t       scan_piece,
   output logic                         busy,
   output logic                         done,
   output logic signed [EVAL_WIDTH-1:0] score
);

   import chess_pkg::*;

   typedef enum logic {
      st_idle,
      st_scan
   } state_t;

   state_t                  state;
   sq_index_t               idx_q;     // Square being read this cycle
   logic signed [EVAL_WIDTH-1:0] acc_q;     // Running sum
   logic signed [EVAL_WIDTH-1:0] value_ext; // Unsigned piece value, widened
   logic signed [EVAL_WIDTH-1:0] acc_next;

   assign scan_index = idx_q;
   assign busy       = (state == st_scan);

   // Values stay below 1000 so any width from 16 up holds them as positive
   assign value_ext = EVAL_WIDTH'(piece_value(scan_piece));

   always_comb
   begin
      if (scan_piece[color_bit])
         acc_next = acc_q - value_ext;  // Black counts against
      else
         acc_next = acc_q + value_ext;  // White or empty
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state <= st_idle;
         idx_q <= '0;
         acc_q <= '0;
         done  <= 1'b0;
         score <= '0;
      end
      else
      begin
         done <= 1'b0;                  // Pulse by default
         case (state)
            st_idle:
            begin
               if (start)
               begin
                  state <= st_scan;
                  idx_q <= '0;
                  acc_q <= '0;
               end
            end
            st_scan:
            begin
               acc_q <= acc_next;
               if (idx_q == sq_index_t'(63))
               begin
                  score <= acc_next;    // Last square folded in
                  done  <= 1'b1;
                  state <= st_idle;
               end
               else
                  idx_q <= idx_q + 1'b1;
            end
            default:
               state <= st_idle;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- tb_chess_eval_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_chess_eval_top;

   import chess_pkg::*;

   localparam int EVAL_WIDTH     = 22;
   localparam int TIMEOUT_CYCLES = 20000;   // About 30 runs of under 250 cycles, plus margin

   logic        clk = 1'b0;
   logic        rst_n;
   logic        reg_wr;
   logic        reg_rd;
   reg_addr_t   reg_addr;
   logic [31:0] reg_wdata;
   logic [31:0] reg_rdata;

   piece_t      ref_board [64];             // Mirror of accepted board changes
   logic        chk_valid;                  // Compare registered read data at next edge
   logic [31:0] chk_mask;
   logic [31:0] chk_exp;
   reg_addr_t   chk_addr;
   int          cycle_count = 0;
   integer      seed = 32'h8e39;

   chess_eval_top #(
      .EVAL_WIDTH (EVAL_WIDTH)
   ) u_chess_eval_top (
      .clk       (clk),
      .rst_n     (rst_n),
      .reg_wr    (reg_wr),
      .reg_rd    (reg_rd),
      .reg_addr  (reg_addr),
      .reg_wdata (reg_wdata),
      .reg_rdata (reg_rdata)
   );

   always #2 clk = ~clk;                    // 4 ns period

   always @(posedge clk)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES)
      begin
         $display("Timeout after %0d cycles, the test sequence never completed", cycle_count);
         $display("CHECKS FAILED");
         $fatal(1);
      end
   end

   task automatic stop_on_error(input string msg);
      $display("%s", msg);
      $display("CHECKS FAILED");
      $fatal(1);
   endtask

   // Read data held by the DUT, sampled one edge after capture
   read_check: assert property (@(posedge clk) disable iff (!rst_n)
      chk_valid |-> ((reg_rdata & chk_mask) == chk_exp))
   else
      stop_on_error($sformatf("Error at %0t: addr %0d read %h, expected %h",
                              $time, chk_addr, reg_rdata & chk_mask, chk_exp));

   // Signed material of one square, white positive
   function automatic int piece_worth(input logic [3:0] code);
      int v;
      case (code[2:0])
         3'd1:    v = 100;                  // Pawn
         3'd2:    v = 320;                  // Knight
         3'd3:    v = 330;                  // Bishop
         3'd4:    v = 500;                  // Rook
         3'd5:    v = 900;                  // Queen
         default: v = 0;                    // King, empty
      endcase
      return code[3] ? -v : v;
   endfunction

   function automatic int model_score();
      int sum;
      sum = 0;
      for (int i = 0; i < 64; i++)
         sum += piece_worth(ref_board[i]);
      return sum;
   endfunction

   task automatic model_opening();
      piece_t back [8];
      back = '{pc_w_rook, pc_w_knit, pc_w_bish, pc_w_quen,
               pc_w_king, pc_w_bish, pc_w_knit, pc_w_rook};
      for (int i = 0; i < 64; i++)
         ref_board[i] = pc_empty;
      for (int f = 0; f < 8; f++)
      begin
         ref_board[f]      = back[f];
         ref_board[8 + f]  = pc_w_pawn;
         ref_board[48 + f] = pc_b_pawn;
         ref_board[56 + f] = piece_t'(back[f] | 4'h8); // Black back rank
      end
   endtask

   task automatic write_reg(input reg_addr_t addr, input logic [31:0] data);
      reg_wr    = 1'b1;
      reg_addr  = addr;
      reg_wdata = data;
      @(posedge clk);
      #0.5;
      reg_wr = 1'b0;
   endtask

   task automatic read_reg(input reg_addr_t addr, output logic [31:0] data);
      reg_rd   = 1'b1;
      reg_addr = addr;
      @(posedge clk);
      #0.5;
      reg_rd = 1'b0;
      data   = reg_rdata;                   // Registered, stable here
   endtask

   task automatic check_reg(input reg_addr_t addr, input logic [31:0] mask,
                            input logic [31:0] exp_data);
      logic [31:0] data;
      read_reg(addr, data);
      chk_addr  = addr;
      chk_mask  = mask;
      chk_exp   = exp_data;
      chk_valid = 1'b1;                     // Checked by read_check
      @(posedge clk);
      #0.5;
      chk_valid = 1'b0;
   endtask

   task automatic place_piece(input sq_index_t sq, input piece_t pc);
      write_reg(reg_square, {22'd0, sq, pc});
      ref_board[sq] = pc;
   endtask

   task automatic clear_board();
      write_reg(reg_cmd, 32'h2);
      for (int i = 0; i < 64; i++)
         ref_board[i] = pc_empty;
   endtask

   task automatic load_opening();
      write_reg(reg_cmd, 32'h4);
      model_opening();
   endtask

   task automatic start_eval();
      write_reg(reg_cmd, 32'h1);
      check_reg(reg_status, 32'h3, 32'h1);  // Busy set, old done cleared
   endtask

   task automatic finish_eval();
      logic [31:0] status;
      int          expected;
      expected = model_score();
      status   = '0;
      check_reg(reg_status, 32'h3, 32'h1);  // Scan under way
      while (!status[1])                    // Poll for sticky done
      begin
         read_reg(reg_status, status);
         assert (!(status[0] && status[1]))
         else
            stop_on_error($sformatf("Error at %0t: status shows busy and done together",
                                    $time));
      end
      check_reg(reg_status, 32'hffff_ffff, 32'h2);        // Idle, done held
      check_reg(reg_eval, 32'hffff_ffff, 32'(expected));  // Sign extended score
   endtask

   task automatic run_eval();
      start_eval();
      finish_eval();
   endtask

   initial
   begin
      int        count;
      sq_index_t sq;
      piece_t    pc;
      rst_n      = 1'b0;
      reg_wr     = 1'b0;
      reg_rd     = 1'b0;
      reg_addr   = reg_cmd;
      reg_wdata  = '0;
      chk_valid  = 1'b0;
      chk_mask   = '0;
      chk_exp    = '0;
      chk_addr   = reg_cmd;
      pc         = pc_empty;
      model_opening();                      // Board resets to opening
      repeat (8) @(posedge clk);
      #0.5;
      rst_n = 1'b1;

      check_reg(reg_status, 32'hffff_ffff, 32'h0);
      check_reg(reg_eval, 32'hffff_ffff, 32'h0);
      run_eval();                           // Untouched board

      clear_board();
      place_piece(6'd3, pc_w_quen);         // d1
      place_piece(6'd56, pc_b_rook);        // a8
      run_eval();
      check_reg(reg_eval, 32'hffff_ffff, 32'd400);
      check_reg(reg_square, 32'hffff_ffff, {28'd0, pc_b_rook});

      for (int p = 0; p < 20; p++)          // Random positions
      begin
         clear_board();
         count = 1 + ($random(seed) & 15);
         for (int k = 0; k < count; k++)
         begin
            sq = 6'($random(seed));
            pc = piece_t'({1'($random(seed)), 3'(1 + ($unsigned($random(seed)) % 6))});
            place_piece(sq, pc);
         end
         check_reg(reg_square, 32'hffff_ffff, {28'd0, pc});
         run_eval();
      end

      load_opening();
      run_eval();
      check_reg(reg_eval, 32'hffff_ffff, 32'h0);

      clear_board();
      place_piece(6'd12, pc_w_knit);
      place_piece(6'd51, pc_b_bish);
      place_piece(6'd40, pc_b_pawn);        // Model gives -110
      start_eval();
      write_reg(reg_square, {22'd0, 6'd0, pc_w_quen}); // All four dropped while busy
      write_reg(reg_cmd, 32'h2);
      write_reg(reg_cmd, 32'h1);
      write_reg(reg_cmd, 32'h4);
      finish_eval();
      check_reg(reg_square, 32'hffff_ffff, {28'd0, pc_b_pawn}); // Selection kept
      run_eval();                           // Board unchanged by dropped writes

      for (int a = 4; a < 8; a++)           // Unused addresses
         check_reg(reg_addr_t'(3'(a)), 32'hffff_ffff, 32'h0);

      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule

`default_nettype wire
